/* decode_stage.sv */
`timescale 1ns/1ps
// Instruction decoder, immediate generation, register file and ID/EX register
module decode_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall_i,
    input  logic            flush_i,
    input  rv_pkg::if_id_t  if_id_i,
    input  rv_pkg::mem_wb_t mem_wb_i,
    output rv_pkg::id_ex_t  id_ex_o
);

    rv_pkg::instr_u          instr;
    rv_pkg::ctrl_t           ctrl;
    rv_pkg::id_ex_t          id_ex_d;
    rv_pkg::id_ex_t          id_ex_q;
    logic [rv_pkg::XLEN-1:0] imm;
    logic [rv_pkg::XLEN-1:0] regs [32];
    logic                    rf_we;

    assign instr = if_id_i.instr;

    //////////////////////////////////////////////////
    // Control decode

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = rv_pkg::alu_add;
        ctrl.wb_sel = rv_pkg::wb_alu;
        case (instr.r.opcode)
            rv_pkg::opc_op, rv_pkg::opc_op_imm: begin
                ctrl.use_imm   = (instr.r.opcode == rv_pkg::opc_op_imm);
                ctrl.reg_write = 1'b1;
                case (instr.r.funct3)
                    3'b000: begin
                        // SUB only exists in the register form
                        if (!ctrl.use_imm && instr.r.funct7[5]) begin
                            ctrl.alu_op = rv_pkg::alu_sub;
                        end
                    end
                    3'b010:  ctrl.alu_op = rv_pkg::alu_slt;
                    3'b100:  ctrl.alu_op = rv_pkg::alu_xor;
                    3'b110:  ctrl.alu_op = rv_pkg::alu_or;
                    3'b111:  ctrl.alu_op = rv_pkg::alu_and;
                    default: ctrl.alu_op = rv_pkg::alu_add;
                endcase
            end
            rv_pkg::opc_lui: begin
                ctrl.alu_op    = rv_pkg::alu_pass_b;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::opc_load: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_load;
            end
            rv_pkg::opc_store: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            rv_pkg::opc_branch: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = instr.b.funct3[0];
            end
            rv_pkg::opc_jal: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_link;
            end
            default: ;
        endcase
        // Writes to x0 are dropped here so nothing downstream sees them
        if (instr.r.rd == '0) begin
            ctrl.reg_write = 1'b0;
        end
        if (!if_id_i.valid) begin
            ctrl = '0;
        end
    end

    // Immediate per format
    always_comb begin
        case (instr.r.opcode)
            rv_pkg::opc_store:
                imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            rv_pkg::opc_branch:
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            rv_pkg::opc_lui:
                imm = {instr.i.imm, instr.i.rs1, instr.i.funct3, 12'b0};
            // J immediate lives in the upper 20 bits of the I view
            rv_pkg::opc_jal:
                imm = {{12{instr.i.imm[11]}}, instr.i.rs1, instr.i.funct3,
                       instr.i.imm[0], instr.i.imm[10:1], 1'b0};
            default:
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
        endcase
    end

    //////////////////////////////////////////////////
    // Register file

    assign rf_we = mem_wb_i.valid && mem_wb_i.reg_write && mem_wb_i.rd != '0;

    always_ff @(posedge clk) begin
        if (rf_we) begin
            regs[mem_wb_i.rd] <= mem_wb_i.wb_data;
        end
    end

    // Reads see a same-cycle writeback
    always_comb begin
        id_ex_d          = '0;
        id_ex_d.valid    = if_id_i.valid;
        id_ex_d.pc       = if_id_i.pc;
        id_ex_d.imm      = imm;
        id_ex_d.rs1      = instr.r.rs1;
        id_ex_d.rs2      = instr.r.rs2;
        id_ex_d.rd       = instr.r.rd;
        id_ex_d.ctrl     = ctrl;
        id_ex_d.rs1_data = (instr.r.rs1 == '0) ? '0 :
                           (rf_we && mem_wb_i.rd == instr.r.rs1) ? mem_wb_i.wb_data :
                           regs[instr.r.rs1];
        id_ex_d.rs2_data = (instr.r.rs2 == '0) ? '0 :
                           (rf_we && mem_wb_i.rd == instr.r.rs2) ? mem_wb_i.wb_data :
                           regs[instr.r.rs2];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex_q <= '0;
        end else if (stall_i || flush_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        mem_wb_i.valid && mem_wb_i.reg_write |-> mem_wb_i.rd != '0)
        else $error("writeback to x0 reached the register file");

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps
// Operand forwarding, ALU, branch and jump resolution, EX/MEM register
module execute_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pkg::id_ex_t          id_ex_i,
    input  rv_pkg::fwd_sel_e        fwd_a_i,
    input  rv_pkg::fwd_sel_e        fwd_b_i,
    input  logic [rv_pkg::XLEN-1:0] mem_fwd_i,
    input  rv_pkg::mem_wb_t         mem_wb_i,
    output logic                    redirect_o,
    output logic [rv_pkg::XLEN-1:0] redirect_pc_o,
    output rv_pkg::ex_mem_t         ex_mem_o
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_b;
    logic [rv_pkg::XLEN-1:0] alu_y;
    logic                    ex_valid;
    logic                    redirect_q;
    rv_pkg::ex_mem_t         ex_mem_q;

    function automatic logic [rv_pkg::XLEN-1:0] fwd_pick(
        input rv_pkg::fwd_sel_e        sel,
        input logic [rv_pkg::XLEN-1:0] rf_val,
        input logic [rv_pkg::XLEN-1:0] mem_val,
        input logic [rv_pkg::XLEN-1:0] wb_val
    );
        case (sel)
            rv_pkg::fwd_from_mem: return mem_val;
            rv_pkg::fwd_from_wb:  return wb_val;
            default:              return rf_val;
        endcase
    endfunction

    assign op_a  = fwd_pick(fwd_a_i, id_ex_i.rs1_data, mem_fwd_i, mem_wb_i.wb_data);
    assign op_b  = fwd_pick(fwd_b_i, id_ex_i.rs2_data, mem_fwd_i, mem_wb_i.wb_data);
    assign alu_b = id_ex_i.ctrl.use_imm ? id_ex_i.imm : op_b;

    // Instruction right behind a redirect belongs to the wrong path
    assign ex_valid = id_ex_i.valid && !redirect_q;

    //////////////////////////////////////////////////
    // ALU

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            rv_pkg::alu_sub:    alu_y = op_a - alu_b;
            rv_pkg::alu_and:    alu_y = op_a & alu_b;
            rv_pkg::alu_or:     alu_y = op_a | alu_b;
            rv_pkg::alu_xor:    alu_y = op_a ^ alu_b;
            rv_pkg::alu_slt:    alu_y = {31'b0, $signed(op_a) < $signed(alu_b)};
            rv_pkg::alu_pass_b: alu_y = alu_b;
            default:            alu_y = op_a + alu_b;
        endcase
    end

    // BEQ and BNE compare the forwarded register operands
    assign redirect_o = ex_valid &&
                        (id_ex_i.ctrl.jump ||
                         (id_ex_i.ctrl.branch && ((op_a == op_b) ^ id_ex_i.ctrl.branch_ne)));
    assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_q <= 1'b0;
            ex_mem_q   <= '0;
        end else begin
            redirect_q          <= redirect_o;
            ex_mem_q.valid      <= ex_valid;
            ex_mem_q.alu_result <= alu_y;
            ex_mem_q.store_data <= op_b;
            ex_mem_q.link_pc    <= id_ex_i.pc + 32'd4;
            ex_mem_q.rd         <= id_ex_i.rd;
            ex_mem_q.ctrl       <= ex_valid ? id_ex_i.ctrl : '0;
        end
    end

    assign ex_mem_o = ex_mem_q;

    // Decode turns the slot behind a redirect into a bubble
    a_redirect_flushes: assert property (@(posedge clk) disable iff (rst)
        redirect_o |=> !id_ex_i.valid)
        else $error("instruction behind a redirect reached execute");

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps
// Program counter, next-PC selection and IF/ID pipeline register
module fetch_stage #(
    parameter int IMEM_AW = 14
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  logic                    redirect_i,
    input  logic [rv_pkg::XLEN-1:0] redirect_pc_i,
    output logic [IMEM_AW-1:0]      imem_addr_o,
    input  logic [rv_pkg::XLEN-1:0] imem_instr_i,
    output rv_pkg::if_id_t          if_id_o
);

    logic [rv_pkg::XLEN-1:0] pc_q;
    rv_pkg::if_id_t          if_id_q;

    // Word address into instruction memory
    assign imem_addr_o = pc_q[IMEM_AW+1:2];

    // Redirect from execute wins over a load-use hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= '0;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_id_q <= '0;
        end else if (flush_i) begin
            if_id_q <= '0;
        end else if (!stall_i) begin
            if_id_q.valid <= 1'b1;
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= imem_instr_i;
        end
    end

    assign if_id_o = if_id_q;

endmodule

/* flist.f */
+incdir+.
rv_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
rv_core.sv
tb_rv_core.sv

/* hazard_unit.sv */
`timescale 1ns/1ps
// Forwarding selects, load-use stall and flush on redirect
module hazard_unit (
    input  logic [rv_pkg::REG_ADDR_W-1:0] id_rs1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] id_rs2_i,
    input  rv_pkg::id_ex_t                id_ex_i,
    input  rv_pkg::ex_mem_t               ex_mem_i,
    input  rv_pkg::mem_wb_t               mem_wb_i,
    input  logic                          redirect_i,
    output logic                          stall_o,
    output logic                          flush_o,
    output rv_pkg::fwd_sel_e              fwd_a_o,
    output rv_pkg::fwd_sel_e              fwd_b_o
);

    logic load_use;

    // Memory stage is younger so it wins over writeback
    function automatic rv_pkg::fwd_sel_e fwd_pick(
        input logic [rv_pkg::REG_ADDR_W-1:0] rs,
        input rv_pkg::ex_mem_t               ex_mem,
        input rv_pkg::mem_wb_t               mem_wb
    );
        if (rs == '0) begin
            return rv_pkg::fwd_none;
        end
        if (ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.rd == rs) begin
            return rv_pkg::fwd_from_mem;
        end
        if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd == rs) begin
            return rv_pkg::fwd_from_wb;
        end
        return rv_pkg::fwd_none;
    endfunction

    assign fwd_a_o = fwd_pick(id_ex_i.rs1, ex_mem_i, mem_wb_i);
    assign fwd_b_o = fwd_pick(id_ex_i.rs2, ex_mem_i, mem_wb_i);

    // Load in execute feeding the instruction in decode
    assign load_use = id_ex_i.valid && id_ex_i.ctrl.mem_read && id_ex_i.rd != '0 &&
                      (id_ex_i.rd == id_rs1_i || id_ex_i.rd == id_rs2_i);

    // Flush has priority, the held instruction is discarded anyway
    assign stall_o = load_use && !redirect_i;
    assign flush_o = redirect_i;

    // A load in execute can never be the redirecting instruction
    always_comb begin
        a_stall_vs_flush: assert #0 (!(load_use && redirect_i))
            else $error("load-use stall raised together with a redirect");
    end

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps
// Data memory request, writeback select and MEM/WB register
module memory_stage #(
    parameter int DMEM_AW = 14
) (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pkg::ex_mem_t         ex_mem_i,
    output rv_pkg::dm_req_t         dm_req_o,
    input  logic [rv_pkg::XLEN-1:0] dm_rdata_i,
    output logic [rv_pkg::XLEN-1:0] mem_fwd_o,
    output rv_pkg::mem_wb_t         mem_wb_o
);

    logic [rv_pkg::XLEN-1:0] wb_val;
    rv_pkg::mem_wb_t         mem_wb_q;

    // Address bits above the memory size read as zero
    assign dm_req_o.web   = !(ex_mem_i.valid && ex_mem_i.ctrl.mem_write);
    assign dm_req_o.addr  = (rv_pkg::XLEN-2)'(ex_mem_i.alu_result[DMEM_AW+1:2]);
    assign dm_req_o.wdata = ex_mem_i.store_data;

    always_comb begin
        case (ex_mem_i.ctrl.wb_sel)
            rv_pkg::wb_load: wb_val = dm_rdata_i;
            rv_pkg::wb_link: wb_val = ex_mem_i.link_pc;
            default:         wb_val = ex_mem_i.alu_result;
        endcase
    end

    // Forwarded to execute as the value MEM/WB will capture
    assign mem_fwd_o = wb_val;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.valid     <= ex_mem_i.valid;
            mem_wb_q.wb_data   <= wb_val;
            mem_wb_q.rd        <= ex_mem_i.rd;
            mem_wb_q.reg_write <= ex_mem_i.valid && ex_mem_i.ctrl.reg_write;
        end
    end

    assign mem_wb_o = mem_wb_q;

    a_store_aligned: assert property (@(posedge clk) disable iff (rst)
        !dm_req_o.web |-> ex_mem_i.alu_result[1:0] == 2'b00)
        else $error("misaligned store address %h", ex_mem_i.alu_result);

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_rv_core -o sim_tb \
    && ./obj_dir/sim_tb || exit 1

/* rv_core.sv */
`timescale 1ns/1ps
// Five-stage RV32I pipeline top level with instruction and data memory ports
module rv_core #(
    parameter int IMEM_AW = 14,
    parameter int DMEM_AW = 14
) (
    input  logic                    clk,
    input  logic                    rst,
    output logic [IMEM_AW-1:0]      imem_addr_o,
    input  logic [rv_pkg::XLEN-1:0] imem_instr_i,
    output rv_pkg::dm_req_t         dm_req_o,
    input  logic [rv_pkg::XLEN-1:0] dm_rdata_i
);

    rv_pkg::if_id_t          if_id;
    rv_pkg::id_ex_t          id_ex;
    rv_pkg::ex_mem_t         ex_mem;
    rv_pkg::mem_wb_t         mem_wb;
    rv_pkg::fwd_sel_e        fwd_a;
    rv_pkg::fwd_sel_e        fwd_b;
    logic                    stall;
    logic                    flush;
    logic                    redirect;
    logic [rv_pkg::XLEN-1:0] redirect_pc;
    logic [rv_pkg::XLEN-1:0] mem_fwd;

    //////////////////////////////////////////////////
    // Pipeline stages

    fetch_stage #(.IMEM_AW(IMEM_AW)) u_fetch (
        .clk(clk), .rst(rst),
        .stall_i(stall), .flush_i(flush),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .imem_addr_o(imem_addr_o), .imem_instr_i(imem_instr_i),
        .if_id_o(if_id)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst),
        .stall_i(stall), .flush_i(flush),
        .if_id_i(if_id), .mem_wb_i(mem_wb),
        .id_ex_o(id_ex)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst),
        .id_ex_i(id_ex),
        .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
        .mem_fwd_i(mem_fwd), .mem_wb_i(mem_wb),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .ex_mem_o(ex_mem)
    );

    memory_stage #(.DMEM_AW(DMEM_AW)) u_memory (
        .clk(clk), .rst(rst),
        .ex_mem_i(ex_mem),
        .dm_req_o(dm_req_o), .dm_rdata_i(dm_rdata_i),
        .mem_fwd_o(mem_fwd), .mem_wb_o(mem_wb)
    );

    // Decode source registers come straight from the IF/ID word
    hazard_unit u_hazard (
        .id_rs1_i(if_id.instr.r.rs1), .id_rs2_i(if_id.instr.r.rs2),
        .id_ex_i(id_ex), .ex_mem_i(ex_mem), .mem_wb_i(mem_wb),
        .redirect_i(redirect),
        .stall_o(stall), .flush_o(flush),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
    );

endmodule

/* rv_pkg.sv */
// Core constants, opcode and ALU enums, instruction formats, stage and memory structs
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    //////////////////////////////////////////////////
    // Encodings

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_link
    } wb_sel_e;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_from_mem,
        fwd_from_wb
    } fwd_sel_e;

    //////////////////////////////////////////////////
    // Instruction word views

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } instr_s_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } instr_b_t;

    // One word, decoded through the view that its opcode calls for
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
    } instr_u;

    //////////////////////////////////////////////////
    // Pipeline registers

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    jump;
        wb_sel_e wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_u          instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        ctrl_t                 ctrl;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [XLEN-1:0]       link_pc;
        logic [REG_ADDR_W-1:0] rd;
        ctrl_t                 ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       wb_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
    } mem_wb_t;

    // Data memory port, write strobe active low
    typedef struct packed {
        logic            web;
        logic [XLEN-3:0] addr;
        logic [XLEN-1:0] wdata;
    } dm_req_t;

endpackage

/* tb_program.svh */
// Instruction encoders, test program image and expected store list
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int OPC_OP     = 'h33;
localparam int OPC_OP_IMM = 'h13;
localparam int OPC_LOAD   = 'h03;
localparam int RES_BASE   = 'h100;

int pc_n = 0;

//////////////////////////////////////////////////
// RV32I encoders

function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd,
                                      input int rs1, input int rs2);
    return f7 << 25 | rs2 << 20 | rs1 << 15 | f3 << 12 | rd << 7 | OPC_OP;
endfunction

function automatic logic [31:0] enc_i(input int opc, input int rd, input int f3,
                                      input int rs1, input int imm);
    return (imm & 'hfff) << 20 | rs1 << 15 | f3 << 12 | rd << 7 | opc;
endfunction

function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
    return ((imm >> 5) & 'h7f) << 25 | rs2 << 20 | rs1 << 15 | 2 << 12 |
           (imm & 'h1f) << 7 | 'h23;
endfunction

function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
                                      input int imm);
    return ((imm >> 12) & 1) << 31 | ((imm >> 5) & 'h3f) << 25 | rs2 << 20 |
           rs1 << 15 | f3 << 12 | ((imm >> 1) & 'hf) << 8 | ((imm >> 11) & 1) << 7 | 'h63;
endfunction

function automatic logic [31:0] enc_j(input int rd, input int imm);
    return ((imm >> 20) & 1) << 31 | ((imm >> 1) & 'h3ff) << 21 |
           ((imm >> 11) & 1) << 20 | ((imm >> 12) & 'hff) << 12 | rd << 7 | 'h6f;
endfunction

function automatic logic [31:0] enc_u(input int rd, input int imm20);
    return imm20 << 12 | rd << 7 | 'h37;
endfunction

task automatic emit(input logic [31:0] word);
    imem[pc_n] = word;
    pc_n++;
endtask

// SW relative to x31, with the word the ISA says must land there
task automatic emit_store(input int rs2, input int offset, input logic [31:0] value);
    emit(enc_s(rs2, 31, offset));
    exp_addr[n_exp] = 30'((RES_BASE + offset) >> 2);
    exp_data[n_exp] = value;
    n_exp++;
endtask

task automatic build_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] t15;
    logic [31:0] t16;
    int          jal_pc;
    a = 1234;
    b = -77;
    emit(enc_i(OPC_OP_IMM, 31, 0, 0, RES_BASE));
    emit(enc_i(OPC_OP_IMM, 1, 0, 0, 1234));
    emit(enc_i(OPC_OP_IMM, 2, 0, 0, -77));
    // Register and immediate ALU ops
    emit(enc_r(0, 0, 3, 1, 2));
    emit_store(3, 0, a + b);
    emit(enc_r('h20, 0, 4, 2, 1));
    emit_store(4, 4, b - a);
    emit(enc_r(0, 2, 5, 2, 1));
    emit_store(5, 8, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    emit(enc_r(0, 2, 6, 1, 2));
    emit_store(6, 12, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    emit(enc_r(0, 7, 7, 1, 2));
    emit_store(7, 16, a & b);
    emit(enc_r(0, 6, 8, 1, 2));
    emit_store(8, 20, a | b);
    emit(enc_r(0, 4, 9, 1, 2));
    emit_store(9, 24, a ^ b);
    emit(enc_i(OPC_OP_IMM, 10, 7, 1, 'hf0));
    emit_store(10, 28, a & 32'h0000_00f0);
    emit(enc_i(OPC_OP_IMM, 11, 6, 2, 'h321));
    emit_store(11, 32, b | 32'h0000_0321);
    emit(enc_i(OPC_OP_IMM, 12, 4, 1, -1));
    emit_store(12, 36, a ^ 32'hffff_ffff);
    emit(enc_i(OPC_OP_IMM, 13, 2, 2, -76));
    emit_store(13, 40, ($signed(b) < -76) ? 32'd1 : 32'd0);
    emit(enc_u(14, 'habcde));
    emit_store(14, 44, 32'habcd_e000);
    // Dependent chain at distance 1 and 2
    t15 = a + 5;
    t15 = t15 + t15;
    t16 = t15 - a;
    emit(enc_i(OPC_OP_IMM, 15, 0, 1, 5));
    emit(enc_r(0, 0, 15, 15, 15));
    emit(enc_r('h20, 0, 16, 15, 1));
    emit(enc_r(0, 0, 17, 15, 16));
    emit_store(17, 48, t15 + t16);
    // Loads of seeded words, each used right away
    emit(enc_i(OPC_LOAD, 18, 2, 0, 0));
    emit(enc_i(OPC_LOAD, 20, 2, 0, 4));
    emit(enc_r(0, 0, 19, 18, 20));
    emit_store(19, 52, seed_words[0] + seed_words[1]);
    emit(enc_i(OPC_LOAD, 21, 2, 0, 8));
    emit_store(21, 56, seed_words[2]);
    emit(enc_i(OPC_LOAD, 22, 2, 0, 12));
    emit(enc_r(0, 4, 23, 22, 1));
    emit_store(23, 60, seed_words[3] ^ a);
    // Taken BEQ over two shadow stores
    emit(enc_b(0, 1, 1, 12));
    emit(enc_s(1, 31, 'h700));
    emit(enc_s(2, 31, 'h704));
    emit(enc_b(1, 3, 3, 8));
    emit_store(2, 64, b);
    jal_pc = pc_n * 4;
    emit(enc_j(24, 12));
    emit(enc_s(1, 31, 'h708));
    emit(enc_s(2, 31, 'h70c));
    emit_store(24, 68, 32'(jal_pc + 4));
    emit(enc_i(OPC_OP_IMM, 0, 0, 0, 55));
    emit_store(0, 72, 32'd0);
    emit(enc_j(0, 0));
endtask

`endif

/* tb_rv_core.sv */
`timescale 1ns/1ps
// Testbench for rv_core with memory models, store checks, timeout and pass/fail
module tb_rv_core;

    localparam int          IMEM_AW     = 8;
    localparam int          DMEM_AW     = 10;
    localparam int          N_MAX       = 32;
    localparam int          CYCLE_LIMIT = 400;
    localparam logic [31:0] SEED        = 32'h48de_439e;
    // Shadow-slot stores aim at this word and above
    localparam logic [29:0] SHADOW_WORD = 30'd512;

    logic               clk;
    logic               rst;
    logic [IMEM_AW-1:0] imem_addr;
    logic [31:0]        imem_instr;
    logic [31:0]        dm_rdata;
    rv_pkg::dm_req_t    dm_req;

    logic [31:0] imem [2**IMEM_AW];
    logic [31:0] dmem [2**DMEM_AW];
    logic [31:0] seed_words [4];
    logic [29:0] exp_addr [N_MAX];
    logic [31:0] exp_data [N_MAX];
    int          n_exp = 0;
    int          store_idx = 0;
    int          cycles = 0;

    `include "tb_program.svh"

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display(">>> FAIL");
        $display("Fail %s got %h expected %h", name, got, exp);
        $fatal(1, "value check failed");
    endtask

    task automatic report_error(input string msg);
        $display(">>> FAIL");
        $display("%s", msg);
        $fatal(1, "run aborted");
    endtask

    rv_core #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) u_rv_core (
        .clk(clk), .rst(rst),
        .imem_addr_o(imem_addr), .imem_instr_i(imem_instr),
        .dm_req_o(dm_req), .dm_rdata_i(dm_rdata)
    );

    //////////////////////////////////////////////////
    // Clock, reset and memories

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        logic [31:0] x;
        rst = 1'b1;
        x = SEED;
        for (int i = 0; i < 2**IMEM_AW; i++) begin
            imem[i] = enc_i(OPC_OP_IMM, 0, 0, 0, i);
        end
        for (int i = 0; i < 2**DMEM_AW; i++) begin
            dmem[i] = 32'h5a5a_0000 ^ 32'(i);
        end
        for (int i = 0; i < 4; i++) begin
            x = xorshift(x);
            seed_words[i] = x;
            dmem[i] = x;
        end
        build_program();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

    assign imem_instr = imem[imem_addr];
    assign dm_rdata   = dmem[dm_req.addr[DMEM_AW-1:0]];

    always @(posedge clk) begin
        if (!dm_req.web) begin
            dmem[dm_req.addr[DMEM_AW-1:0]] <= dm_req.wdata;
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            store_idx <= 0;
        end else if (!dm_req.web) begin
            store_idx <= store_idx + 1;
        end
    end

    //////////////////////////////////////////////////
    // Checks

    a_web_in_reset: assert property (@(posedge clk) rst |-> dm_req.web)
        else report_error("store strobe active during reset");

    a_pc_after_reset: assert property (@(posedge clk) $fell(rst) |-> imem_addr == '0)
        else report_mismatch("imem_addr_o", 32'($sampled(imem_addr)), 32'd0);

    a_store_count: assert property (@(posedge clk) disable iff (rst)
        !dm_req.web |-> store_idx < n_exp)
        else report_error("more stores seen than the program makes");

    a_no_shadow_store: assert property (@(posedge clk) disable iff (rst)
        !dm_req.web |-> dm_req.addr < SHADOW_WORD)
        else report_error("a store from a flushed shadow slot reached memory");

    a_store_addr: assert property (@(posedge clk) disable iff (rst)
        !dm_req.web |-> dm_req.addr == exp_addr[store_idx])
        else report_mismatch("dm_req_o.addr", {2'b00, $sampled(dm_req.addr)},
                             {2'b00, exp_addr[$sampled(store_idx)]});

    a_store_data: assert property (@(posedge clk) disable iff (rst)
        !dm_req.web |-> dm_req.wdata == exp_data[store_idx])
        else report_mismatch("dm_req_o.wdata", $sampled(dm_req.wdata),
                             exp_data[$sampled(store_idx)]);

    // Run ends after the last expected store or at the cycle limit
    always @(posedge clk) begin
        if (rst) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
        if (cycles >= CYCLE_LIMIT) begin
            report_error("timeout before all expected stores were seen");
        end else if (!rst && n_exp > 0 && store_idx == n_exp) begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule
